// ==== run.sh ====
#!/bin/sh
# Build and run the allocate stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_alloc -o tb_alloc
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_alloc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$LOG"; then
	exit 1
fi
exit 0

// ==== tb.f ====
verilog/alloc_pkg.sv
verilog/gpr_file.sv
verilog/frc_timer.sv
verilog/sysreg_bank.sv
verilog/operand_latch.sv
verilog/alloc_stage.sv
verif/tb_alloc.sv

// ==== verif/tb_alloc.sv ====
`timescale 1ns/1ps

module tb_alloc;
	import alloc_pkg::*;

	localparam logic [WORD_W-1:0] SPR_INIT = 32'h0000_F000;
	// The directed tests need well under a hundred cycles
	localparam int CYCLE_LIMIT = 2000;

	logic iCLOCK;
	logic inRESET;
	logic event_hold, event_start, event_irq_entry, event_irq_return, event_pcr_set;
	logic [WORD_W-1:0] event_pcr;
	logic prev_valid, prev_destination_sysreg, prev_writeback;
	logic prev_source0_sysreg, prev_source1_sysreg, prev_source1_imm, prev_lock;
	logic [4:0] prev_cmd;
	logic [REG_ADDR_W-1:0] prev_destination, prev_source0;
	logic [WORD_W-1:0] prev_pc, prev_source1;
	logic wb_valid, wb_writeback, wb_destination_sysreg;
	logic [REG_ADDR_W-1:0] wb_destination;
	logic [WORD_W-1:0] wb_data, wb_pc;
	logic next_lock, next_valid, next_destination_sysreg, next_writeback;
	logic [4:0] next_cmd;
	logic [REG_ADDR_W-1:0] next_destination;
	logic [WORD_W-1:0] next_source0, next_source1, next_pc, next_psr, next_spr;
	logic [FRC_W-1:0] next_frcr;
	logic [WORD_W-1:0] psr, ppsr, idtr, pcr, spr;

	integer seed;
	int errors;
	int checks;
	int tests;
	int cycle_count = 0;
	logic [WORD_W-1:0] gpr_model [32];

	alloc_stage #(.SPR_INIT(SPR_INIT)) dut (.*);

	always #10 iCLOCK = ~iCLOCK;

	always @(posedge iCLOCK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	// Inputs change 2 ns after the rising edge
	task automatic step();
		@(posedge iCLOCK);
		#2;
	endtask

	task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic idle_inputs();
		event_hold = 1'b0;
		event_start = 1'b0;
		event_irq_entry = 1'b0;
		event_irq_return = 1'b0;
		event_pcr_set = 1'b0;
		event_pcr = '0;
		prev_valid = 1'b0;
		prev_cmd = '0;
		prev_destination = '0;
		prev_destination_sysreg = 1'b0;
		prev_writeback = 1'b0;
		prev_pc = '0;
		prev_source0 = '0;
		prev_source0_sysreg = 1'b0;
		prev_source1 = '0;
		prev_source1_sysreg = 1'b0;
		prev_source1_imm = 1'b0;
		wb_valid = 1'b0;
		wb_writeback = 1'b0;
		wb_destination = '0;
		wb_destination_sysreg = 1'b0;
		wb_data = '0;
		wb_pc = '0;
		next_lock = 1'b0;
	endtask

	task automatic write_back(input logic [REG_ADDR_W-1:0] idx, input logic sys,
		input logic [WORD_W-1:0] data);
		wb_valid = 1'b1;
		wb_writeback = 1'b1;
		wb_destination = idx;
		wb_destination_sysreg = sys;
		wb_data = data;
		step();
		if (!sys) begin
			gpr_model[idx] = data;
		end
		wb_valid = 1'b0;
		wb_writeback = 1'b0;
	endtask

	task automatic issue(input logic [REG_ADDR_W-1:0] src0, input logic src0_sys,
		input logic [WORD_W-1:0] src1, input logic src1_sys, input logic src1_imm);
		prev_valid = 1'b1;
		prev_source0 = src0;
		prev_source0_sysreg = src0_sys;
		prev_source1 = src1;
		prev_source1_sysreg = src1_sys;
		prev_source1_imm = src1_imm;
		step();
		prev_valid = 1'b0;
	endtask

	task automatic finish_test(input string name, input int start);
		tests++;
		if (errors == start) begin
			$display("%s: ok", name);
		end
		else begin
			$display("%s: %0d errors", name, errors - start);
		end
	endtask

	task automatic gpr_path();
		logic [WORD_W-1:0] imm;
		int start;
		start = errors;
		idle_inputs();
		for (int r = 1; r < 6; r++) begin
			write_back(5'(r), 1'b0, $random(seed));
		end
		for (int r = 1; r < 5; r++) begin
			issue(5'(r), 1'b0, 32'(r + 1), 1'b0, 1'b0);
			compare(64'(next_valid), 64'd1, "gpr read valid");
			compare(64'(next_source0), 64'(gpr_model[r]), "gpr read source0");
			compare(64'(next_source1), 64'(gpr_model[r + 1]), "gpr read source1");
		end
		imm = $random(seed);
		issue(5'd1, 1'b0, imm, 1'b0, 1'b1);
		compare(64'(next_source1), 64'(imm), "immediate source1");
		finish_test("gpr path", start);
	endtask

	task automatic forward_and_hold();
		logic [WORD_W-1:0] data;
		int start;
		start = errors;
		idle_inputs();
		data = $random(seed);
		wb_valid = 1'b1;
		wb_writeback = 1'b1;
		wb_destination = 5'd3;
		wb_data = data;
		issue(5'd3, 1'b0, 32'd3, 1'b0, 1'b0);
		gpr_model[3] = data;
		compare(64'(next_source0), 64'(data), "forwarded source0");
		compare(64'(next_source1), 64'(data), "forwarded source1");
		// Hold blocks the write but the bypass still sees wb_data
		data = $random(seed);
		event_hold = 1'b1;
		wb_destination = 5'd4;
		wb_data = data;
		issue(5'd4, 1'b0, 32'd0, 1'b0, 1'b0);
		compare(64'(next_source0), 64'(data), "forward under hold");
		event_hold = 1'b0;
		wb_valid = 1'b0;
		wb_writeback = 1'b0;
		issue(5'd4, 1'b0, 32'd0, 1'b0, 1'b0);
		compare(64'(next_source0), 64'(gpr_model[4]), "write dropped under hold");
		finish_test("forwarding and hold", start);
	endtask

	task automatic lock_and_flush();
		logic [WORD_W-1:0] pc;
		int start;
		start = errors;
		idle_inputs();
		pc = $random(seed);
		prev_cmd = 5'h0a;
		prev_destination = 5'd7;
		prev_destination_sysreg = 1'b1;
		prev_writeback = 1'b1;
		prev_pc = pc;
		issue(5'd2, 1'b0, 32'd5, 1'b0, 1'b0);
		compare(64'(next_valid), 64'd1, "valid before lock");
		next_lock = 1'b1;
		prev_valid = 1'b1;
		prev_cmd = 5'h15;
		prev_destination = 5'd9;
		prev_destination_sysreg = 1'b0;
		prev_writeback = 1'b0;
		prev_source0 = 5'd3;
		prev_pc = ~pc;
		step();
		step();
		compare(64'(next_valid), 64'd0, "valid under lock");
		compare(64'(prev_lock), 64'd1, "prev_lock under lock");
		compare(64'(next_cmd), 64'h0a, "cmd held under lock");
		compare(64'(next_destination), 64'd7, "destination held under lock");
		compare(64'(next_destination_sysreg), 64'd1, "destination sysreg held under lock");
		compare(64'(next_writeback), 64'd1, "writeback held under lock");
		compare(64'(next_pc), 64'(pc), "pc held under lock");
		compare(64'(next_source0), 64'(gpr_model[2]), "source0 held under lock");
		next_lock = 1'b0;
		prev_valid = 1'b0;
		#1;
		compare(64'(next_valid), 64'd1, "valid after release");
		compare(64'(next_cmd), 64'h0a, "cmd after release");
		compare(64'(next_pc), 64'(pc), "pc after release");
		step();
		// A flush beats a new issue in the same cycle
		prev_valid = 1'b1;
		prev_cmd = 5'h1f;
		prev_destination_sysreg = 1'b1;
		prev_writeback = 1'b1;
		event_start = 1'b1;
		step();
		event_start = 1'b0;
		prev_valid = 1'b0;
		compare(64'(next_valid), 64'd0, "valid after flush");
		compare(64'(next_cmd), 64'd0, "cmd after flush");
		compare(64'(next_destination), 64'd0, "destination after flush");
		compare(64'(next_destination_sysreg), 64'd0, "destination sysreg after flush");
		compare(64'(next_writeback), 64'd0, "writeback after flush");
		compare(64'(next_source0), 64'd0, "source0 after flush");
		compare(64'(next_source1), 64'd0, "source1 after flush");
		compare(64'(next_pc), 64'd0, "pc after flush");
		finish_test("lock and flush", start);
	endtask

	task automatic sysreg_and_irq();
		logic [WORD_W-1:0] old_psr;
		logic [WORD_W-1:0] value;
		int start;
		start = errors;
		idle_inputs();
		compare(64'(spr), 64'(SPR_INIT), "spr after reset");
		compare(64'(next_spr), 64'(SPR_INIT), "next_spr after reset");
		old_psr = $random(seed);
		old_psr[6:5] = 2'b11;
		old_psr[2] = 1'b1;
		write_back(SYSREG_PSR, 1'b1, old_psr);
		compare(64'(psr), 64'(old_psr), "psr write");
		compare(64'(next_psr), 64'(old_psr), "next_psr write");
		value = $random(seed);
		write_back(SYSREG_IDTR, 1'b1, value);
		compare(64'(idtr), 64'(value), "idtr write");
		event_irq_entry = 1'b1;
		step();
		event_irq_entry = 1'b0;
		compare(64'(ppsr), 64'(old_psr), "ppsr saved on entry");
		compare(64'(psr), 64'(old_psr & ~32'h0000_0064), "psr masked on entry");
		compare(64'(next_psr), 64'(old_psr & ~32'h0000_0064), "next_psr masked on entry");
		event_irq_return = 1'b1;
		step();
		event_irq_return = 1'b0;
		compare(64'(psr), 64'(old_psr), "psr restored on return");
		value = $random(seed);
		prev_pc = value;
		issue(SYSREG_PCR, 1'b1, 32'd0, 1'b0, 1'b0);
		compare(64'(next_source0), 64'(value - 32'd4), "pcr source read");
		value = $random(seed);
		event_pcr_set = 1'b1;
		event_pcr = value;
		step();
		event_pcr_set = 1'b0;
		compare(64'(pcr), 64'(value), "pcr event load");
		finish_test("system registers and interrupts", start);
	endtask

	task automatic timer_load();
		logic [WORD_W-1:0] lo;
		logic [WORD_W-1:0] hi;
		logic [FRC_W-1:0] expected;
		int start;
		start = errors;
		idle_inputs();
		lo = $random(seed);
		hi = $random(seed);
		write_back(SYSREG_FRCLR, 1'b1, lo);
		write_back(SYSREG_FRCHR, 1'b1, hi);
		expected = {hi, lo};
		write_back(SYSREG_FRCR, 1'b1, 32'd0);
		compare(next_frcr, expected, "frc load value");
		for (int i = 1; i < 4; i++) begin
			step();
			compare(next_frcr, expected + 64'(i), "frc count after load");
		end
		finish_test("timer", start);
	endtask

	initial begin
		seed = 32'h9c63_2ac1;
		errors = 0;
		checks = 0;
		tests = 0;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		idle_inputs();
		for (int r = 0; r < 32; r++) begin
			gpr_model[r] = '0;
		end
		repeat (2) @(posedge iCLOCK);
		#2;
		inRESET = 1'b1;
		step();
		gpr_path();
		forward_and_hold();
		lock_and_flush();
		sysreg_and_irq();
		timer_load();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end
		else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== verilog/alloc_pkg.sv ====
package alloc_pkg;

	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int FRC_W      = 64;

	// Instruction size that a PCR read takes off the previous PC
	localparam logic [WORD_W-1:0] PC_STEP = 32'd4;

	// System register indices
	localparam logic [REG_ADDR_W-1:0] SYSREG_SPR   = 5'd0;
	localparam logic [REG_ADDR_W-1:0] SYSREG_PSR   = 5'd1;
	localparam logic [REG_ADDR_W-1:0] SYSREG_IDTR  = 5'd2;
	localparam logic [REG_ADDR_W-1:0] SYSREG_PPSR  = 5'd3;
	localparam logic [REG_ADDR_W-1:0] SYSREG_PCR   = 5'd4;
	localparam logic [REG_ADDR_W-1:0] SYSREG_FRCLR = 5'd5;
	localparam logic [REG_ADDR_W-1:0] SYSREG_FRCHR = 5'd6;
	localparam logic [REG_ADDR_W-1:0] SYSREG_FRCR  = 5'd7;

	typedef struct packed {
		logic [24:0] upper;
		logic [1:0]  mode;
		logic [1:0]  mid;
		logic        irq_en;
		logic [1:0]  low;
	} psr_fields_t;

	// Raw word for writeback, fields for interrupt entry
	typedef union packed {
		logic [WORD_W-1:0] raw;
		psr_fields_t       fields;
	} psr_word_u;

endpackage

// ==== verilog/alloc_stage.sv ====
`timescale 1ns/1ps

module alloc_stage #(
	parameter logic [alloc_pkg::WORD_W-1:0] SPR_INIT = 32'h0000_F000
) (
	input  logic                             iCLOCK,
	input  logic                             inRESET,
	input  logic                             event_hold,
	input  logic                             event_start,
	input  logic                             event_irq_entry,
	input  logic                             event_irq_return,
	input  logic                             event_pcr_set,
	input  logic [alloc_pkg::WORD_W-1:0]     event_pcr,
	input  logic                             prev_valid,
	input  logic [4:0]                       prev_cmd,
	input  logic [alloc_pkg::REG_ADDR_W-1:0] prev_destination,
	input  logic                             prev_destination_sysreg,
	input  logic                             prev_writeback,
	input  logic [alloc_pkg::WORD_W-1:0]     prev_pc,
	input  logic [alloc_pkg::REG_ADDR_W-1:0] prev_source0,
	input  logic                             prev_source0_sysreg,
	input  logic [alloc_pkg::WORD_W-1:0]     prev_source1,
	input  logic                             prev_source1_sysreg,
	input  logic                             prev_source1_imm,
	output logic                             prev_lock,
	input  logic                             wb_valid,
	input  logic                             wb_writeback,
	input  logic [alloc_pkg::REG_ADDR_W-1:0] wb_destination,
	input  logic                             wb_destination_sysreg,
	input  logic [alloc_pkg::WORD_W-1:0]     wb_data,
	input  logic [alloc_pkg::WORD_W-1:0]     wb_pc,
	input  logic                             next_lock,
	output logic                             next_valid,
	output logic [4:0]                       next_cmd,
	output logic [alloc_pkg::REG_ADDR_W-1:0] next_destination,
	output logic                             next_destination_sysreg,
	output logic                             next_writeback,
	output logic [alloc_pkg::WORD_W-1:0]     next_source0,
	output logic [alloc_pkg::WORD_W-1:0]     next_source1,
	output logic [alloc_pkg::WORD_W-1:0]     next_pc,
	output logic [alloc_pkg::WORD_W-1:0]     next_psr,
	output logic [alloc_pkg::WORD_W-1:0]     next_spr,
	output logic [alloc_pkg::FRC_W-1:0]      next_frcr,
	output logic [alloc_pkg::WORD_W-1:0]     psr,
	output logic [alloc_pkg::WORD_W-1:0]     ppsr,
	output logic [alloc_pkg::WORD_W-1:0]     idtr,
	output logic [alloc_pkg::WORD_W-1:0]     pcr,
	output logic [alloc_pkg::WORD_W-1:0]     spr
);
	import alloc_pkg::*;

	logic [WORD_W-1:0] rd0_data;
	logic [WORD_W-1:0] rd1_data;
	logic [WORD_W-1:0] sys0_data;
	logic [WORD_W-1:0] sys1_data;
	logic              frc_load;
	logic [FRC_W-1:0]  frc_load_value;

	gpr_file u_gpr (
		.iCLOCK, .inRESET, .wb_valid, .wb_writeback, .wb_destination_sysreg, .event_hold,
		.wb_destination, .wb_data,
		.rd0_addr(prev_source0),
		.rd1_addr(prev_source1[REG_ADDR_W-1:0]),
		.rd0_data, .rd1_data
	);

	sysreg_bank #(.SPR_INIT(SPR_INIT)) u_sysreg (
		.iCLOCK, .inRESET, .event_hold, .event_irq_entry, .event_irq_return,
		.event_pcr_set, .event_pcr, .wb_valid, .wb_writeback, .wb_destination_sysreg,
		.wb_destination, .wb_data, .wb_pc, .prev_pc,
		.sys0_addr(prev_source0),
		.sys1_addr(prev_source1[REG_ADDR_W-1:0]),
		.sys0_data, .sys1_data, .psr, .ppsr, .idtr, .pcr, .spr,
		.frc_load, .frc_load_value
	);

	frc_timer u_frc (
		.iCLOCK, .inRESET, .frc_load, .frc_load_value,
		.frc_count(next_frcr)
	);

	operand_latch u_latch (
		.iCLOCK, .inRESET, .event_start, .next_lock,
		.prev_valid, .prev_cmd, .prev_destination, .prev_destination_sysreg,
		.prev_writeback, .prev_pc, .prev_source0, .prev_source0_sysreg,
		.prev_source1, .prev_source1_sysreg, .prev_source1_imm,
		.wb_valid, .wb_writeback, .wb_destination_sysreg, .wb_destination, .wb_data,
		.rd0_data, .rd1_data, .sys0_data, .sys1_data,
		.next_valid, .next_cmd, .next_destination, .next_destination_sysreg,
		.next_writeback, .next_source0, .next_source1, .next_pc
	);

	// Lock passes straight back, so a stalled issue stays with the previous stage
	assign prev_lock = next_lock;
	assign next_psr  = psr;
	assign next_spr  = spr;

endmodule

// ==== verilog/frc_timer.sv ====
`timescale 1ns/1ps

module frc_timer (
	input  logic                        iCLOCK,
	input  logic                        inRESET,
	input  logic                        frc_load,
	input  logic [alloc_pkg::FRC_W-1:0] frc_load_value,
	output logic [alloc_pkg::FRC_W-1:0] frc_count
);
	import alloc_pkg::*;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			frc_count <= '0;
		end
		else if (frc_load) begin
			frc_count <= frc_load_value;
		end
		else begin
			frc_count <= frc_count + FRC_W'(1);
		end
	end

	// Software load lands exactly on the next edge
	a_load_lands: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		frc_load |=> frc_count == $past(frc_load_value)
	);

endmodule

// ==== verilog/gpr_file.sv ====
`timescale 1ns/1ps

module gpr_file (
	input  logic                             iCLOCK,
	input  logic                             inRESET,
	input  logic                             wb_valid,
	input  logic                             wb_writeback,
	input  logic                             wb_destination_sysreg,
	input  logic                             event_hold,
	input  logic [alloc_pkg::REG_ADDR_W-1:0] wb_destination,
	input  logic [alloc_pkg::WORD_W-1:0]     wb_data,
	input  logic [alloc_pkg::REG_ADDR_W-1:0] rd0_addr,
	input  logic [alloc_pkg::REG_ADDR_W-1:0] rd1_addr,
	output logic [alloc_pkg::WORD_W-1:0]     rd0_data,
	output logic [alloc_pkg::WORD_W-1:0]     rd1_data
);
	import alloc_pkg::*;

	localparam int DEPTH = 2 ** REG_ADDR_W;

	logic [WORD_W-1:0] regs [DEPTH];
	logic              wr_en;

	// Only general register writebacks, never while events hold the core
	assign wr_en = wb_valid && wb_writeback && !wb_destination_sysreg && !event_hold;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < DEPTH; i++) begin
				regs[i] <= '0;
			end
		end
		else if (wr_en) begin
			regs[wb_destination] <= wb_data;
		end
	end

	assign rd0_data = regs[rd0_addr];
	assign rd1_data = regs[rd1_addr];

endmodule

// ==== verilog/operand_latch.sv ====
`timescale 1ns/1ps

module operand_latch (
	input  logic                             iCLOCK,
	input  logic                             inRESET,
	input  logic                             event_start,
	input  logic                             next_lock,
	input  logic                             prev_valid,
	input  logic [4:0]                       prev_cmd,
	input  logic [alloc_pkg::REG_ADDR_W-1:0] prev_destination,
	input  logic                             prev_destination_sysreg,
	input  logic                             prev_writeback,
	input  logic [alloc_pkg::WORD_W-1:0]     prev_pc,
	input  logic [alloc_pkg::REG_ADDR_W-1:0] prev_source0,
	input  logic                             prev_source0_sysreg,
	input  logic [alloc_pkg::WORD_W-1:0]     prev_source1,
	input  logic                             prev_source1_sysreg,
	input  logic                             prev_source1_imm,
	input  logic                             wb_valid,
	input  logic                             wb_writeback,
	input  logic                             wb_destination_sysreg,
	input  logic [alloc_pkg::REG_ADDR_W-1:0] wb_destination,
	input  logic [alloc_pkg::WORD_W-1:0]     wb_data,
	input  logic [alloc_pkg::WORD_W-1:0]     rd0_data,
	input  logic [alloc_pkg::WORD_W-1:0]     rd1_data,
	input  logic [alloc_pkg::WORD_W-1:0]     sys0_data,
	input  logic [alloc_pkg::WORD_W-1:0]     sys1_data,
	output logic                             next_valid,
	output logic [4:0]                       next_cmd,
	output logic [alloc_pkg::REG_ADDR_W-1:0] next_destination,
	output logic                             next_destination_sysreg,
	output logic                             next_writeback,
	output logic [alloc_pkg::WORD_W-1:0]     next_source0,
	output logic [alloc_pkg::WORD_W-1:0]     next_source1,
	output logic [alloc_pkg::WORD_W-1:0]     next_pc
);
	import alloc_pkg::*;

	logic              valid_q;
	logic [WORD_W-1:0] src0_sel;
	logic [WORD_W-1:0] src1_sel;

	// Forwarded data beats the register read, except PCR which tracks prev_pc
	function automatic logic [WORD_W-1:0] pick_operand(
		input logic [REG_ADDR_W-1:0] idx,
		input logic                  is_sys,
		input logic [WORD_W-1:0]     sys_data,
		input logic [WORD_W-1:0]     gpr_data
	);
		logic hit;
		hit = wb_valid && wb_writeback && (wb_destination == idx)
			&& (wb_destination_sysreg == is_sys) && !(is_sys && idx == SYSREG_PCR);
		if (hit) return wb_data;
		else if (is_sys) return sys_data;
		else return gpr_data;
	endfunction

	always_comb begin
		src0_sel = pick_operand(prev_source0, prev_source0_sysreg, sys0_data, rd0_data);
		if (prev_source1_imm) begin
			src1_sel = prev_source1;
		end
		else begin
			src1_sel = pick_operand(prev_source1[REG_ADDR_W-1:0], prev_source1_sysreg,
				sys1_data, rd1_data);
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET || event_start) begin
			valid_q                 <= 1'b0;
			next_cmd                <= '0;
			next_destination        <= '0;
			next_destination_sysreg <= 1'b0;
			next_writeback          <= 1'b0;
			next_source0            <= '0;
			next_source1            <= '0;
			next_pc                 <= '0;
		end
		else if (!next_lock) begin
			valid_q                 <= prev_valid;
			next_cmd                <= prev_cmd;
			next_destination        <= prev_destination;
			next_destination_sysreg <= prev_destination_sysreg;
			next_writeback          <= prev_writeback;
			next_source0            <= src0_sel;
			next_source1            <= src1_sel;
			next_pc                 <= prev_pc;
		end
	end

	assign next_valid = valid_q && !next_lock;

	// A stalled item stays in the stage register until execute takes it
	a_hold_under_lock: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		next_lock && !event_start |=> $stable(valid_q) && $stable(next_cmd)
			&& $stable(next_pc) && $stable(next_source0) && $stable(next_source1)
	);

endmodule

// ==== verilog/sysreg_bank.sv ====
`timescale 1ns/1ps

module sysreg_bank #(
	parameter logic [alloc_pkg::WORD_W-1:0] SPR_INIT = 32'h0000_F000
) (
	input  logic                             iCLOCK,
	input  logic                             inRESET,
	input  logic                             event_hold,
	input  logic                             event_irq_entry,
	input  logic                             event_irq_return,
	input  logic                             event_pcr_set,
	input  logic [alloc_pkg::WORD_W-1:0]     event_pcr,
	input  logic                             wb_valid,
	input  logic                             wb_writeback,
	input  logic                             wb_destination_sysreg,
	input  logic [alloc_pkg::REG_ADDR_W-1:0] wb_destination,
	input  logic [alloc_pkg::WORD_W-1:0]     wb_data,
	input  logic [alloc_pkg::WORD_W-1:0]     wb_pc,
	input  logic [alloc_pkg::WORD_W-1:0]     prev_pc,
	input  logic [alloc_pkg::REG_ADDR_W-1:0] sys0_addr,
	input  logic [alloc_pkg::REG_ADDR_W-1:0] sys1_addr,
	output logic [alloc_pkg::WORD_W-1:0]     sys0_data,
	output logic [alloc_pkg::WORD_W-1:0]     sys1_data,
	output logic [alloc_pkg::WORD_W-1:0]     psr,
	output logic [alloc_pkg::WORD_W-1:0]     ppsr,
	output logic [alloc_pkg::WORD_W-1:0]     idtr,
	output logic [alloc_pkg::WORD_W-1:0]     pcr,
	output logic [alloc_pkg::WORD_W-1:0]     spr,
	output logic                             frc_load,
	output logic [alloc_pkg::FRC_W-1:0]      frc_load_value
);
	import alloc_pkg::*;

	psr_word_u         psr_q;
	logic [WORD_W-1:0] ppsr_q;
	logic [WORD_W-1:0] idtr_q;
	logic [WORD_W-1:0] spr_q;
	logic [WORD_W-1:0] pcr_q;
	logic [WORD_W-1:0] frclr_q;
	logic [WORD_W-1:0] frchr_q;
	logic              sys_wr;

	assign sys_wr = wb_valid && wb_writeback && wb_destination_sysreg && !event_hold;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			psr_q   <= '0;
			ppsr_q  <= '0;
			idtr_q  <= '0;
			spr_q   <= SPR_INIT;
			pcr_q   <= '0;
			frclr_q <= '0;
			frchr_q <= '0;
		end
		else begin
			// Interrupt entry masks and drops to mode 0
			if (event_irq_entry) begin
				psr_q.fields.mode   <= 2'b00;
				psr_q.fields.irq_en <= 1'b0;
				ppsr_q              <= psr_q.raw;
			end
			else if (event_irq_return) begin
				psr_q.raw <= ppsr_q;
			end
			else if (sys_wr) begin
				case (wb_destination)
					SYSREG_PSR:   psr_q.raw <= wb_data;
					SYSREG_PPSR:  ppsr_q    <= wb_data;
					default:      ;
				endcase
			end
			if (sys_wr) begin
				case (wb_destination)
					SYSREG_SPR:   spr_q   <= wb_data;
					SYSREG_IDTR:  idtr_q  <= wb_data;
					SYSREG_FRCLR: frclr_q <= wb_data;
					SYSREG_FRCHR: frchr_q <= wb_data;
					default:      ;
				endcase
			end
			// Event set wins, else track the retiring PC
			if (event_pcr_set) begin
				pcr_q <= event_pcr;
			end
			else if (wb_valid && !event_hold) begin
				pcr_q <= wb_pc;
			end
		end
	end

	function automatic logic [WORD_W-1:0] read_sysreg(input logic [REG_ADDR_W-1:0] idx);
		case (idx)
			SYSREG_SPR:   return spr_q;
			SYSREG_PSR:   return psr_q.raw;
			SYSREG_IDTR:  return idtr_q;
			SYSREG_PPSR:  return ppsr_q;
			SYSREG_PCR:   return prev_pc - PC_STEP;
			SYSREG_FRCLR: return frclr_q;
			SYSREG_FRCHR: return frchr_q;
			default:      return '0;
		endcase
	endfunction

	always_comb begin
		sys0_data = read_sysreg(sys0_addr);
		sys1_data = read_sysreg(sys1_addr);
	end

	// Writing FRCR copies both halves into the timer
	assign frc_load       = sys_wr && (wb_destination == SYSREG_FRCR);
	assign frc_load_value = {frchr_q, frclr_q};

	assign psr  = psr_q.raw;
	assign ppsr = ppsr_q;
	assign idtr = idtr_q;
	assign pcr  = pcr_q;
	assign spr  = spr_q;

	a_irq_exclusive: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!(event_irq_entry && event_irq_return)
	);

endmodule
